// ==== common/fpu_cmp_pkg.sv ====
// compare unit package: op codes, tag width, request, result and writeback structs
`default_nettype none

package fpu_cmp_pkg;

  // tag width, enough to tell apart results in flight
  localparam int tag_width_c = 4;

  // operation codes, 5 to 7 are illegal
  typedef enum logic [2:0] {
    OP_FEQ  = 3'd0,
    OP_FLT  = 3'd1,
    OP_FLE  = 3'd2,
    OP_FMIN = 3'd3,
    OP_FMAX = 3'd4
  } fp_op_e;

  // registered request from issue to writeback
  typedef struct packed {
    fp_op_e                 op;
    logic [tag_width_c-1:0] tag;
  } cmp_req_t;

  // single-bit comparator results
  typedef struct packed {
    logic eq;
    logic lt;
    logic le;
    // flt and fle, any NaN input
    logic lt_le_invalid;
    // feq, signaling NaN only
    logic eq_invalid;
    logic min_max_invalid;
  } cmp_res_t;

  // output sideband
  typedef struct packed {
    logic [tag_width_c-1:0] tag;
    fp_op_e                 op;
    logic                   nv;
  } wb_info_t;

endpackage

`default_nettype wire

// ==== fpu_cmp/fpu_classify.sv ====
// fpu_classify: zero, NaN, signaling NaN, infinity and sign of one operand
`timescale 1ns/1ns
`default_nettype none

module fpu_classify #(
  parameter int e_p = 8
  , parameter int m_p = 23
) (
  input  logic [e_p+m_p:0] fp_i
  , output logic           zero_o
  , output logic           nan_o
  , output logic           sig_nan_o
  , output logic           infty_o
  , output logic           sign_o
);

  logic [e_p-1:0] exp;
  logic [m_p-1:0] man;
  logic           exp_ones;
  logic           exp_zero;
  logic           man_zero;
  logic           man_top;

  // field split
  assign sign_o = fp_i[e_p+m_p];
  assign exp    = fp_i[m_p+:e_p];
  assign man    = fp_i[0+:m_p];

  assign exp_ones = &exp;
  assign exp_zero = ~|exp;
  assign man_zero = ~|man;
  // quiet bit of a NaN
  assign man_top  = man[m_p-1];

  // denormals count as ordinary finite values here
  assign zero_o    = exp_zero & man_zero;
  assign infty_o   = exp_ones & man_zero;
  assign nan_o     = exp_ones & ~man_zero;
  assign sig_nan_o = nan_o & ~man_top;

endmodule

`default_nettype wire

// ==== fpu_cmp/fpu_cmp_n.sv ====
// fpu_cmp_n: combinational compare (eq, lt, le), min-max and invalid conditions
`timescale 1ns/1ns
`default_nettype none

module fpu_cmp_n #(
  parameter int e_p = 8
  , parameter int m_p = 23
) (
  input  logic [e_p+m_p:0]        a_i
  , input  logic [e_p+m_p:0]      b_i
  , output fpu_cmp_pkg::cmp_res_t res_o
  , output logic [e_p+m_p:0]      min_o
  , output logic [e_p+m_p:0]      max_o
);

  localparam int width_lp = e_p + m_p + 1;

  // canonical quiet NaN and positive zero
  localparam logic [width_lp-1:0] qnan_lp = {1'b0, {e_p{1'b1}}, 1'b1, {(m_p-1){1'b0}}};
  localparam logic [width_lp-1:0] pzero_lp = '0;

  logic a_zero, a_nan, a_sig_nan, a_sign;
  logic b_zero, b_nan, b_sig_nan, b_sign;
  logic mag_a_lt;
  logic eq, lt, le;
  logic lt_le_invalid, eq_invalid, min_max_invalid;

  fpu_classify #(
    .e_p(e_p)
    , .m_p(m_p)
  ) a_class (
    .fp_i(a_i)
    , .zero_o(a_zero)
    , .nan_o(a_nan)
    , .sig_nan_o(a_sig_nan)
    , .infty_o()
    , .sign_o(a_sign)
  );

  fpu_classify #(
    .e_p(e_p)
    , .m_p(m_p)
  ) b_class (
    .fp_i(b_i)
    , .zero_o(b_zero)
    , .nan_o(b_nan)
    , .sig_nan_o(b_sig_nan)
    , .infty_o()
    , .sign_o(b_sign)
  );

  // magnitude is exponent and mantissa taken as one unsigned number
  assign mag_a_lt = a_i[0+:width_lp-1] < b_i[0+:width_lp-1];

  always_comb begin
    lt_le_invalid = a_nan | b_nan;
    eq_invalid    = a_sig_nan | b_sig_nan;
    if (a_nan | b_nan) begin
      eq = 1'b0;
      lt = 1'b0;
      le = 1'b0;
    end else if (a_zero & b_zero) begin
      // +0 and -0 are equal
      eq = 1'b1;
      lt = 1'b0;
      le = 1'b1;
    end else begin
      eq = (a_i == b_i);
      case ({a_sign, b_sign})
        2'b00: begin
          lt = mag_a_lt;
          le = mag_a_lt | eq;
        end
        2'b01: begin
          lt = 1'b0;
          le = 1'b0;
        end
        2'b10: begin
          lt = 1'b1;
          le = 1'b1;
        end
        default: begin
          // both negative, larger magnitude is less
          lt = ~mag_a_lt & ~eq;
          le = ~mag_a_lt;
        end
      endcase
    end
  end

  // min-max, NaN cases first
  always_comb begin
    min_max_invalid = a_sig_nan | b_sig_nan;
    if (a_sig_nan | b_sig_nan | (a_nan & b_nan)) begin
      min_o = qnan_lp;
      max_o = qnan_lp;
    end else if (a_nan) begin
      min_o = b_i;
      max_o = b_i;
    end else if (b_nan) begin
      min_o = a_i;
      max_o = a_i;
    end else if (a_zero & b_zero) begin
      min_o = pzero_lp;
      max_o = pzero_lp;
    end else if (lt) begin
      min_o = a_i;
      max_o = b_i;
    end else begin
      min_o = b_i;
      max_o = a_i;
    end
  end

  assign res_o.eq              = eq;
  assign res_o.lt              = lt;
  assign res_o.le              = le;
  assign res_o.lt_le_invalid   = lt_le_invalid;
  assign res_o.eq_invalid      = eq_invalid;
  assign res_o.min_max_invalid = min_max_invalid;

endmodule

`default_nettype wire

// ==== hdl/fpu_cmp_issue.sv ====
// fpu_cmp_issue: input register stage with op code decode and legality check
`timescale 1ns/1ns
`default_nettype none

module fpu_cmp_issue #(
  parameter int e_p = 8
  , parameter int m_p = 23
) (
  input  logic                                clk_i
  , input  logic                              rst_n_i
  , input  logic                              req_v_i
  , input  logic [2:0]                        req_op_i
  , input  logic [fpu_cmp_pkg::tag_width_c-1:0] req_tag_i
  , input  logic [e_p+m_p:0]                  a_i
  , input  logic [e_p+m_p:0]                  b_i
  , output logic                              iss_v_o
  , output fpu_cmp_pkg::cmp_req_t             iss_req_o
  , output logic [e_p+m_p:0]                  iss_a_o
  , output logic [e_p+m_p:0]                  iss_b_o
);

  logic op_legal;

  // only the five defined codes pass
  always_comb begin
    case (req_op_i)
      fpu_cmp_pkg::OP_FEQ,
      fpu_cmp_pkg::OP_FLT,
      fpu_cmp_pkg::OP_FLE,
      fpu_cmp_pkg::OP_FMIN,
      fpu_cmp_pkg::OP_FMAX: op_legal = 1'b1;
      default:              op_legal = 1'b0;
    endcase
  end

  // valid level, illegal requests dropped here
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      iss_v_o <= 1'b0;
    end else begin
      iss_v_o <= req_v_i & op_legal;
    end
  end

  // payload, loaded on every strobe
  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      iss_req_o.op  <= fpu_cmp_pkg::fp_op_e'(req_op_i);
      iss_req_o.tag <= req_tag_i;
      iss_a_o       <= a_i;
      iss_b_o       <= b_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fpu_cmp_writeback.sv ====
// fpu_cmp_writeback: result select per op, output register and sticky invalid flag
`timescale 1ns/1ns
`default_nettype none

module fpu_cmp_writeback #(
  parameter int e_p = 8
  , parameter int m_p = 23
) (
  input  logic                    clk_i
  , input  logic                  rst_n_i
  , input  logic                  iss_v_i
  , input  fpu_cmp_pkg::cmp_req_t iss_req_i
  , input  fpu_cmp_pkg::cmp_res_t cmp_res_i
  , input  logic [e_p+m_p:0]      min_i
  , input  logic [e_p+m_p:0]      max_i
  , input  logic                  clear_nv_i
  , output logic                  res_v_o
  , output logic [e_p+m_p:0]      res_o
  , output fpu_cmp_pkg::wb_info_t res_info_o
  , output logic                  nv_sticky_o
);

  localparam int width_lp = e_p + m_p + 1;

  logic [width_lp-1:0] res_n;
  logic                nv_n;
  logic                nv_set;

  // compare ops put their bit in bit 0
  always_comb begin
    case (iss_req_i.op)
      fpu_cmp_pkg::OP_FEQ: begin
        res_n = {{(width_lp-1){1'b0}}, cmp_res_i.eq};
        nv_n  = cmp_res_i.eq_invalid;
      end
      fpu_cmp_pkg::OP_FLT: begin
        res_n = {{(width_lp-1){1'b0}}, cmp_res_i.lt};
        nv_n  = cmp_res_i.lt_le_invalid;
      end
      fpu_cmp_pkg::OP_FLE: begin
        res_n = {{(width_lp-1){1'b0}}, cmp_res_i.le};
        nv_n  = cmp_res_i.lt_le_invalid;
      end
      fpu_cmp_pkg::OP_FMIN: begin
        res_n = min_i;
        nv_n  = cmp_res_i.min_max_invalid;
      end
      fpu_cmp_pkg::OP_FMAX: begin
        res_n = max_i;
        nv_n  = cmp_res_i.min_max_invalid;
      end
      default: begin
        res_n = '0;
        nv_n  = 1'b0;
      end
    endcase
  end

  assign nv_set = iss_v_i & nv_n;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      res_v_o     <= 1'b0;
      nv_sticky_o <= 1'b0;
    end else begin
      res_v_o     <= iss_v_i;
      // a new invalid result wins over a clear in the same cycle
      nv_sticky_o <= (nv_sticky_o & ~clear_nv_i) | nv_set;
    end
  end

  // result word and sideband
  always_ff @(posedge clk_i) begin
    if (iss_v_i) begin
      res_o          <= res_n;
      res_info_o.tag <= iss_req_i.tag;
      res_info_o.op  <= iss_req_i.op;
      res_info_o.nv  <= nv_n;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fpu_cmp_unit.sv ====
// fpu_cmp_unit: top level with issue stage, comparator and writeback stage
`timescale 1ns/1ns
`default_nettype none

module fpu_cmp_unit #(
  parameter int e_p = 8
  , parameter int m_p = 23
) (
  input  logic                                  clk_i
  , input  logic                                rst_n_i
  , input  logic                                req_v_i
  , input  logic [2:0]                          req_op_i
  , input  logic [fpu_cmp_pkg::tag_width_c-1:0] req_tag_i
  , input  logic [e_p+m_p:0]                    a_i
  , input  logic [e_p+m_p:0]                    b_i
  , input  logic                                clear_nv_i
  , output logic                                res_v_o
  , output logic [e_p+m_p:0]                    res_o
  , output fpu_cmp_pkg::wb_info_t               res_info_o
  , output logic                                nv_sticky_o
);

  // issue to comparator and writeback
  logic                  iss_v;
  fpu_cmp_pkg::cmp_req_t iss_req;
  logic [e_p+m_p:0]      iss_a;
  logic [e_p+m_p:0]      iss_b;

  // comparator to writeback
  fpu_cmp_pkg::cmp_res_t cmp_res;
  logic [e_p+m_p:0]      min_val;
  logic [e_p+m_p:0]      max_val;

  fpu_cmp_issue #(
    .e_p(e_p)
    , .m_p(m_p)
  ) issue (
    .clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .req_v_i(req_v_i)
    , .req_op_i(req_op_i)
    , .req_tag_i(req_tag_i)
    , .a_i(a_i)
    , .b_i(b_i)
    , .iss_v_o(iss_v)
    , .iss_req_o(iss_req)
    , .iss_a_o(iss_a)
    , .iss_b_o(iss_b)
  );

  fpu_cmp_n #(
    .e_p(e_p)
    , .m_p(m_p)
  ) cmp (
    .a_i(iss_a)
    , .b_i(iss_b)
    , .res_o(cmp_res)
    , .min_o(min_val)
    , .max_o(max_val)
  );

  fpu_cmp_writeback #(
    .e_p(e_p)
    , .m_p(m_p)
  ) writeback (
    .clk_i(clk_i)
    , .rst_n_i(rst_n_i)
    , .iss_v_i(iss_v)
    , .iss_req_i(iss_req)
    , .cmp_res_i(cmp_res)
    , .min_i(min_val)
    , .max_i(max_val)
    , .clear_nv_i(clear_nv_i)
    , .res_v_o(res_v_o)
    , .res_o(res_o)
    , .res_info_o(res_info_o)
    , .nv_sticky_o(nv_sticky_o)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
// tb_clock_gen: free-running testbench clock and synchronous reset pulse
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int half_period_p = 10
  , parameter int reset_cycles_p = 4
) (
  output logic clk_o
  , output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(half_period_p) clk_o = ~clk_o;
  end

  // released on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles_p) @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/fpu_cmp_tb.sv ====
// fpu_cmp_tb: random stimulus, reference model, result queue and checks for fpu_cmp_unit
`timescale 1ns/1ns
`default_nettype none

module fpu_cmp_tb;

  localparam int e_lp = 8;
  localparam int m_lp = 23;
  localparam int w_lp = e_lp + m_lp + 1;
  localparam int tag_w_lp = fpu_cmp_pkg::tag_width_c;
  localparam int num_cycles_lp = 4000;
  localparam int reset_timeout_lp = 20;
  localparam int drain_timeout_lp = 10;
  localparam logic [w_lp-1:0] qnan_lp = 32'h7fc0_0000;

  typedef struct packed {
    logic [31:0]         due;
    logic [w_lp-1:0]     res;
    logic [tag_w_lp-1:0] tag;
    logic [2:0]          op;
    logic                nv;
  } exp_entry_t;

  logic                  clk;
  logic                  rst_n;
  logic                  req_v;
  logic [2:0]            req_op;
  logic [tag_w_lp-1:0]   req_tag;
  logic [w_lp-1:0]       a;
  logic [w_lp-1:0]       b;
  logic                  clear_nv;
  logic                  res_v;
  logic [w_lp-1:0]       res;
  fpu_cmp_pkg::wb_info_t res_info;
  logic                  nv_sticky;

  exp_entry_t  exp_q[$];
  logic [31:0] lcg_state;
  logic [31:0] cycle;
  logic        exp_sticky;
  logic        clear_prev;
  int          n_results;
  int          n_nv;

  tb_clock_gen #(
    .half_period_p(10)
    , .reset_cycles_p(4)
  ) clock_gen (
    .clk_o(clk)
    , .rst_n_o(rst_n)
  );

  fpu_cmp_unit #(
    .e_p(e_lp)
    , .m_p(m_lp)
  ) fpu_cmp_unit_inst (
    .clk_i(clk)
    , .rst_n_i(rst_n)
    , .req_v_i(req_v)
    , .req_op_i(req_op)
    , .req_tag_i(req_tag)
    , .a_i(a)
    , .b_i(b)
    , .clear_nv_i(clear_nv)
    , .res_v_o(res_v)
    , .res_o(res)
    , .res_info_o(res_info)
    , .nv_sticky_o(nv_sticky)
  );

  // LCG with an xor fold so the low bits are usable
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 16);
  endfunction

  function automatic logic is_nan(input logic [w_lp-1:0] x);
    return (&x[m_lp+:e_lp]) && (x[m_lp-1:0] != '0);
  endfunction

  // quiet bit clear
  function automatic logic is_snan(input logic [w_lp-1:0] x);
    return is_nan(x) && !x[m_lp-1];
  endfunction

  function automatic logic is_zero(input logic [w_lp-1:0] x);
    return x[w_lp-2:0] == '0;
  endfunction

  function automatic logic model_eq(input logic [w_lp-1:0] x, input logic [w_lp-1:0] y);
    if (is_nan(x) || is_nan(y)) return 1'b0;
    if (is_zero(x) && is_zero(y)) return 1'b1;
    return x == y;
  endfunction

  function automatic logic model_lt(input logic [w_lp-1:0] x, input logic [w_lp-1:0] y);
    if (is_nan(x) || is_nan(y)) return 1'b0;
    if (is_zero(x) && is_zero(y)) return 1'b0;
    // negative side is less
    if (x[w_lp-1] != y[w_lp-1]) return x[w_lp-1];
    if (!x[w_lp-1]) return x[w_lp-2:0] < y[w_lp-2:0];
    return x[w_lp-2:0] > y[w_lp-2:0];
  endfunction

  function automatic exp_entry_t model_result(input logic [2:0] op,
                                              input logic [tag_w_lp-1:0] tag,
                                              input logic [w_lp-1:0] x,
                                              input logic [w_lp-1:0] y);
    exp_entry_t      e;
    logic            any_nan;
    logic            any_snan;
    logic [w_lp-1:0] lo;
    logic [w_lp-1:0] hi;
    any_nan  = is_nan(x) || is_nan(y);
    any_snan = is_snan(x) || is_snan(y);
    if (any_snan || (is_nan(x) && is_nan(y))) begin
      lo = qnan_lp;
      hi = qnan_lp;
    end else if (is_nan(x)) begin
      lo = y;
      hi = y;
    end else if (is_nan(y)) begin
      lo = x;
      hi = x;
    end else if (is_zero(x) && is_zero(y)) begin
      lo = '0;
      hi = '0;
    end else if (model_lt(x, y)) begin
      lo = x;
      hi = y;
    end else begin
      lo = y;
      hi = x;
    end
    e.due = '0;
    e.tag = tag;
    e.op  = op;
    case (op)
      fpu_cmp_pkg::OP_FEQ: begin
        e.res = {{(w_lp-1){1'b0}}, model_eq(x, y)};
        e.nv  = any_snan;
      end
      fpu_cmp_pkg::OP_FLT: begin
        e.res = {{(w_lp-1){1'b0}}, model_lt(x, y)};
        e.nv  = any_nan;
      end
      fpu_cmp_pkg::OP_FLE: begin
        e.res = {{(w_lp-1){1'b0}}, model_lt(x, y) | model_eq(x, y)};
        e.nv  = any_nan;
      end
      fpu_cmp_pkg::OP_FMIN: begin
        e.res = lo;
        e.nv  = any_snan;
      end
      default: begin
        e.res = hi;
        e.nv  = any_snan;
      end
    endcase
    return e;
  endfunction

  // special values, or a copy of the other operand when allowed
  function automatic logic [w_lp-1:0] pick_operand(input logic [3:0] sel,
                                                   input logic [w_lp-1:0] word,
                                                   input logic [w_lp-1:0] other,
                                                   input logic use_other);
    case (sel)
      4'd5:  return use_other ? (other ^ 32'h1) : word;
      4'd6:  return 32'h0000_0000;
      4'd7:  return 32'h8000_0000;
      4'd8:  return 32'h7f80_0000;
      4'd9:  return 32'hff80_0000;
      4'd10: return {word[31], 8'hff, 1'b1, word[21:0]};
      // payload kept nonzero so it stays a NaN
      4'd11: return {word[31], 8'hff, 1'b0, word[21:1], 1'b1};
      4'd12: return 32'h7f7f_ffff;
      4'd13: return 32'hff7f_ffff;
      4'd14: return use_other ? other : word;
      4'd15: return use_other ? {~other[31], other[30:0]} : word;
      default: return word;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // called on the falling edge, when all DUT outputs are settled
  task automatic check_outputs();
    exp_entry_t e;
    logic       exp_v;
    logic       nv_add;
    exp_v  = (exp_q.size() != 0) && (exp_q[0].due == cycle);
    nv_add = 1'b0;
    if (res_v && exp_q.size() == 0) begin
      $display("TEST FAILED");
      $fatal(1, "result strobe at %0t ns with no request outstanding", $time);
    end
    check_value("res_v_o", 32'(res_v), 32'(exp_v));
    if (exp_v) begin
      e = exp_q.pop_front();
      check_value("res_o", res, e.res);
      check_value("res_info_o.tag", 32'(res_info.tag), 32'(e.tag));
      check_value("res_info_o.op", 32'(res_info.op), 32'(e.op));
      check_value("res_info_o.nv", 32'(res_info.nv), 32'(e.nv));
      nv_add = e.nv;
      n_results++;
      if (e.nv) n_nv++;
    end
    // a delivered invalid result sets the flag even when a clear came with it
    if (nv_add) begin
      exp_sticky = 1'b1;
    end else if (clear_prev) begin
      exp_sticky = 1'b0;
    end
    check_value("nv_sticky_o", 32'(nv_sticky), 32'(exp_sticky));
  endtask

  task automatic drive_random();
    logic [31:0] r_ctl;
    logic [31:0] r_op;
    exp_entry_t  e;
    r_ctl = next_rand();
    r_op  = next_rand();
    req_v = (r_ctl[1:0] != 2'b00);
    // roughly one op in eight is illegal
    if (r_op[7:5] == 3'd0) begin
      req_op = r_op[1] ? 3'd7 : (r_op[0] ? 3'd6 : 3'd5);
    end else begin
      req_op = 3'(r_op[15:8] % 8'd5);
    end
    a = pick_operand(r_ctl[7:4], next_rand(), '0, 1'b0);
    b = pick_operand(r_ctl[15:12], next_rand(), a, 1'b1);
    clear_nv   = (r_ctl[11:8] == 4'd0);
    clear_prev = clear_nv;
    if (req_v) begin
      req_tag = req_tag + 1'b1;
      if (req_op <= 3'd4) begin
        e = model_result(req_op, req_tag, a, b);
        e.due = cycle + 32'd2;
        exp_q.push_back(e);
      end
    end
  endtask

  task automatic drive_idle();
    req_v      = 1'b0;
    clear_nv   = 1'b0;
    clear_prev = 1'b0;
  endtask

  initial begin
    int wait_cnt;
    req_v      = 1'b0;
    req_op     = 3'd0;
    req_tag    = '0;
    a          = '0;
    b          = '0;
    clear_nv   = 1'b0;
    lcg_state  = 32'h9843;
    cycle      = '0;
    exp_sticky = 1'b0;
    clear_prev = 1'b0;
    n_results  = 0;
    n_nv       = 0;
    wait_cnt   = 0;
    while (rst_n !== 1'b1) begin
      if (wait_cnt == reset_timeout_lp) begin
        $display("TEST FAILED");
        $fatal(1, "reset was never released");
      end
      @(posedge clk);
      wait_cnt++;
    end
    for (int i = 0; i < num_cycles_lp; i++) begin
      @(negedge clk);
      cycle = cycle + 32'd1;
      check_outputs();
      drive_random();
    end
    // drain the results still in flight
    wait_cnt = 0;
    while (exp_q.size() != 0 && wait_cnt < drain_timeout_lp) begin
      @(negedge clk);
      cycle = cycle + 32'd1;
      check_outputs();
      drive_idle();
      wait_cnt++;
    end
    if (exp_q.size() == 0) begin
      $display("checked %0d results, %0d with nv set", n_results, n_nv);
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "timeout with %0d results never delivered", exp_q.size());
    end
  end

endmodule

`default_nettype wire

// ==== sim.f ====
common/fpu_cmp_pkg.sv
fpu_cmp/fpu_classify.sv
fpu_cmp/fpu_cmp_n.sv
hdl/fpu_cmp_issue.sv
hdl/fpu_cmp_writeback.sv
hdl/fpu_cmp_unit.sv
tests/tb_clock_gen.sv
tests/fpu_cmp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the compare unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir && \
  verilator --binary --timing --timescale 1ns/1ns -f sim.f \
    --top-module fpu_cmp_tb -o fpu_cmp_sim && \
  ./obj_dir/fpu_cmp_sim || exit 1
